/* src/gty_rx_pkg.sv */
package gty_rx_pkg;

  ////////////////////
  // sizes

  localparam int n_lanes  = 12;                 // lanes in the transceiver quad group
  localparam int word_w   = 160;                // rx user data width per lane
  localparam int err_bit  = 29;                 // bit flipped by induce_error, pre reversal

  ////////////////////
  // rate meter

  // one second of the free running 50 MHz clock
  localparam int gate_period_default = 50_000_000;

  ////////////////////
  // types

  // one received lane word, msb first as delivered by the transceiver
  typedef logic [word_w-1:0] lane_word_t;

  // all lanes side by side, lane 0 in the low slot
  typedef lane_word_t [n_lanes-1:0] lane_bus_t;

  // per lane transceiver status, one bit per lane in each field
  typedef struct packed {
    logic [n_lanes-1:0] powergood;              // gtpowergood
    logic [n_lanes-1:0] cdr_lock;               // rxcdrlock
    logic [n_lanes-1:0] pma_reset_done;         // rxpmaresetdone
  } gt_status_t;

endpackage

/* src/slip_pulse_gen.sv */
`timescale 1ns/1ps

module slip_pulse_gen (
  input  logic                           clk,           // rx user clock
  input  logic                           rst,           // sync, active high
  input  logic [gty_rx_pkg::n_lanes-1:0] gearbox_slip,  // slip request levels
  output logic [gty_rx_pkg::n_lanes-1:0] rxslide        // two cycle slide pulses
);

  ////////////////////
  // edge detect

  logic [gty_rx_pkg::n_lanes-1:0] slip_r;     // registered request
  logic [gty_rx_pkg::n_lanes-1:0] slip_hist;  // previous registered sample
  logic [gty_rx_pkg::n_lanes-1:0] start;      // one cycle strobe per accepted edge
  logic [gty_rx_pkg::n_lanes-1:0] start_d;    // strobe delayed by one, stretches the pulse

  // new rising edge between two registered samples
  assign start = slip_r & ~slip_hist;

  always_ff @(posedge clk) begin
    slip_r <= gearbox_slip;                   // plain input sample
    if (rst) begin
      slip_hist <= slip_r;                    // follow the input so a held level is no edge
      start_d   <= '0;
      rxslide   <= '0;
    end else begin
      slip_hist <= slip_r;
      start_d   <= start;
      rxslide   <= start | start_d;           // strobe or'ed with its delayed copy
    end
  end

  ////////////////////
  // checks

  // requests toggling faster than the pulse would merge into a longer slide
  for (genvar i = 0; i < gty_rx_pkg::n_lanes; i++) begin : g_chk
    a_slide_len : assert property (
      @(posedge clk) disable iff (rst)
      rxslide[i] && $past(rxslide[i]) |=> !rxslide[i]
    ) else $error("rxslide[%0d] held longer than 2 cycles", i);
  end

endmodule

/* src/lane_word_conditioner.sv */
`timescale 1ns/1ps

module lane_word_conditioner (
  input  logic                           clk,          // rx user clock
  input  logic                           rst,          // sync, active high
  input  gty_rx_pkg::lane_bus_t          rx_data,      // raw lane words, new every cycle
  input  logic [gty_rx_pkg::n_lanes-1:0] induce_error, // per lane test error request
  input  gty_rx_pkg::gt_status_t         gt_status,    // per lane transceiver status
  output gty_rx_pkg::lane_bus_t          dout,         // conditioned words, 1 cycle later
  output logic [gty_rx_pkg::n_lanes-1:0] locked        // per lane lock, aligned with dout
);

  ////////////////////
  // per lane datapath

  gty_rx_pkg::lane_bus_t          cond;      // flipped and reversed, before the register
  logic [gty_rx_pkg::n_lanes-1:0] lock_now;  // lock qualification, before the register

  for (genvar i = 0; i < gty_rx_pkg::n_lanes; i++) begin : g_lane
    gty_rx_pkg::lane_word_t err_mask;  // single bit at err_bit when injecting
    gty_rx_pkg::lane_word_t flip;      // word after optional error injection

    assign err_mask = gty_rx_pkg::lane_word_t'(induce_error[i]) << gty_rx_pkg::err_bit;
    assign flip     = rx_data[i] ^ err_mask;

    // transceiver sends lsb first on the line, user side wants it msb first
    // so the injected bit ends up at word_w-1-err_bit
    assign cond[i]  = {<<{flip}};
  end

  // a lane only counts as locked with power, cdr and pma all good
  assign lock_now = gt_status.pma_reset_done & gt_status.cdr_lock & gt_status.powergood;

  ////////////////////
  // output register

  always_ff @(posedge clk) begin
    if (rst) begin
      dout   <= '0;
      locked <= '0;
    end else begin
      dout   <= cond;                         // one stage, every cycle
      locked <= lock_now;                     // same latency as data
    end
  end

  ////////////////////
  // checks

  // lock must drop the cycle after pma reset done falls on any lane
  a_lock_pma : assert property (
    @(posedge clk) disable iff (rst)
    (locked & ~$past(gt_status.pma_reset_done)) == '0
  ) else $error("locked high on a lane without pma reset done");

endmodule

/* src/rx_clock_meter.sv */
`timescale 1ns/1ps

module rx_clock_meter #(
  parameter int gate_period = gty_rx_pkg::gate_period_default  // clk50 cycles per gate
) (
  input  logic        clk50,       // free running reference
  input  logic        rst,         // clk50 domain reset
  input  logic        rx_usrclk,   // recovered clock under measurement
  input  logic        rx_rst,      // rx_usrclk domain reset
  output logic [31:0] rate_count,  // rx cycles in the last full gate
  output logic        rate_valid   // one cycle strobe with a new count
);

  ////////////////////
  // clk50 gate

  logic [31:0] gate_cnt;           // counts clk50 cycles within a gate
  logic        gate_wrap;          // last cycle of the gate
  logic        ready;              // toggles once per gate

  assign gate_wrap = (gate_cnt == 32'(gate_period - 1));

  always_ff @(posedge clk50) begin
    if (rst) begin
      gate_cnt <= '0;
      ready    <= 1'b0;
    end else begin
      gate_cnt <= gate_wrap ? '0 : gate_cnt + 32'd1;
      if (gate_wrap) begin
        ready <= ~ready;                      // level toggle, safe to sync
      end
    end
  end

  ////////////////////
  // crossing into rx_usrclk

  logic ready_meta;                // first sync stage
  logic ready_sync;                // second sync stage
  logic ready_hist;                // last synced value
  logic gate_end;                  // ready changed, gate just closed

  assign gate_end = ready_sync ^ ready_hist;

  always_ff @(posedge rx_usrclk) begin
    if (rx_rst) begin
      ready_meta <= 1'b0;
      ready_sync <= 1'b0;
      ready_hist <= 1'b0;
    end else begin
      ready_meta <= ready;
      ready_sync <= ready_meta;
      ready_hist <= ready_sync;
    end
  end

  ////////////////////
  // rx cycle count

  logic [31:0] cyc_cnt;            // free running rx cycle counter
  logic [31:0] last_snap;          // cyc_cnt at the previous gate end
  logic        rate_first_n;       // low until the partial first gate has passed

  always_ff @(posedge rx_usrclk) begin
    if (rx_rst) begin
      cyc_cnt      <= '0;
      rate_first_n <= 1'b0;
      rate_valid   <= 1'b0;
    end else begin
      cyc_cnt    <= cyc_cnt + 32'd1;          // wraps, difference stays right
      rate_valid <= gate_end & rate_first_n;  // drop the first, partial gate
      if (gate_end) begin
        rate_first_n <= 1'b1;
      end
    end
  end

  // payload only, qualified by rate_valid
  always_ff @(posedge rx_usrclk) begin
    if (gate_end) begin
      rate_count <= cyc_cnt - last_snap;      // cycles since the previous gate end
      last_snap  <= cyc_cnt;
    end
  end

  ////////////////////
  // checks

  // gate ends are many rx cycles apart, so a report is never repeated
  a_valid_single : assert property (
    @(posedge rx_usrclk) disable iff (rx_rst)
    rate_valid |=> !rate_valid
  ) else $error("rate_valid high on two consecutive cycles");

endmodule

/* src/gty_rx_frontend.sv */
`timescale 1ns/1ps

module gty_rx_frontend #(
  parameter int gate_period = gty_rx_pkg::gate_period_default  // rate gate in clk50 cycles
) (
  input  logic                           clk50,         // free running 50 MHz
  input  logic                           rst,           // clk50 domain reset
  input  logic                           rx_usrclk,     // recovered rx user clock
  input  logic                           rx_rst,        // rx_usrclk domain reset

  input  logic [gty_rx_pkg::n_lanes-1:0] gearbox_slip,  // slip requests from user logic
  input  logic [gty_rx_pkg::n_lanes-1:0] induce_error,  // test error injection per lane
  input  gty_rx_pkg::lane_bus_t          rx_data,       // parallel words from the transceiver
  input  gty_rx_pkg::gt_status_t         gt_status,     // transceiver status per lane

  output logic [gty_rx_pkg::n_lanes-1:0] rxslide,       // slide pulses back to the transceiver
  output gty_rx_pkg::lane_bus_t          dout,          // conditioned lane words
  output logic [gty_rx_pkg::n_lanes-1:0] locked,        // per lane lock
  output logic [31:0]                    rate_count,    // rx cycles per gate
  output logic                           rate_valid     // new rate_count strobe
);

  ////////////////////
  // slip handling

  // all in the recovered clock, same as the transceiver's rxslide input
  slip_pulse_gen u_slip (
    .clk          (rx_usrclk),
    .rst          (rx_rst),
    .gearbox_slip (gearbox_slip),
    .rxslide      (rxslide)
  );

  ////////////////////
  // lane data

  lane_word_conditioner u_cond (
    .clk          (rx_usrclk),
    .rst          (rx_rst),
    .rx_data      (rx_data),
    .induce_error (induce_error),
    .gt_status    (gt_status),      // async status, registered next to data
    .dout         (dout),
    .locked       (locked)
  );

  ////////////////////
  // clock rate

  // gate runs on clk50, counting runs on rx_usrclk
  rx_clock_meter #(
    .gate_period (gate_period)
  ) u_meter (
    .clk50      (clk50),
    .rst        (rst),
    .rx_usrclk  (rx_usrclk),
    .rx_rst     (rx_rst),
    .rate_count (rate_count),
    .rate_valid (rate_valid)
  );

endmodule

/* test/tb_gty_rx_frontend.sv */
`timescale 1ns/1ps

module tb_gty_rx_frontend;

  ////////////////////
  // bench constants

  localparam int clk50_ns = 8;                  // clk50 period
  localparam int rx_ns    = 4;                  // rx_usrclk period
  localparam int gate_len = 200;                // short gate so the meter reports often
  localparam int rate_nom = gate_len * clk50_ns / rx_ns;  // rx cycles per gate, 400
  localparam int wd_ns    = 30 * gate_len * clk50_ns + 4000 * rx_ns;

  localparam int n_tests  = 6;
  localparam int t_reset  = 0;
  localparam int t_data   = 1;
  localparam int t_inject = 2;
  localparam int t_slip   = 3;
  localparam int t_lock   = 4;
  localparam int t_meter  = 5;

  ////////////////////
  // DUT signals

  logic                           clk50 = 1'b0;
  logic                           rx_usrclk = 1'b0;
  logic                           rst;
  logic                           rx_rst;
  logic [gty_rx_pkg::n_lanes-1:0] gearbox_slip;
  logic [gty_rx_pkg::n_lanes-1:0] induce_error;
  gty_rx_pkg::lane_bus_t          rx_data;
  gty_rx_pkg::gt_status_t         gt_status;
  logic [gty_rx_pkg::n_lanes-1:0] rxslide;
  gty_rx_pkg::lane_bus_t          dout;
  logic [gty_rx_pkg::n_lanes-1:0] locked;
  logic [31:0]                    rate_count;
  logic                           rate_valid;

  integer seed = 32'h25cb_aad3;                 // fixed seed for $random
  int     errs [n_tests];                       // error count per test
  int     phase;                                // test now driving stimulus

  always #(clk50_ns / 2) clk50 = ~clk50;
  always #(rx_ns / 2) rx_usrclk = ~rx_usrclk;

  gty_rx_frontend #(
    .gate_period (gate_len)
  ) dut (
    .clk50        (clk50),
    .rst          (rst),
    .rx_usrclk    (rx_usrclk),
    .rx_rst       (rx_rst),
    .gearbox_slip (gearbox_slip),
    .induce_error (induce_error),
    .rx_data      (rx_data),
    .gt_status    (gt_status),
    .rxslide      (rxslide),
    .dout         (dout),
    .locked       (locked),
    .rate_count   (rate_count),
    .rate_valid   (rate_valid)
  );

  ////////////////////
  // helpers

  function automatic string test_name(input int t);
    case (t)
      t_reset:  return "reset_state";
      t_data:   return "data_path";
      t_inject: return "error_inject";
      t_slip:   return "slip_pulses";
      t_lock:   return "lock_rule";
      default:  return "clock_meter";
    endcase
  endfunction

  task automatic count_error(input int t);
    errs[t] = errs[t] + 1;
  endtask

  // fills the whole bus from consecutive 32 bit draws
  function automatic gty_rx_pkg::lane_bus_t rand_bus();
    logic [$bits(gty_rx_pkg::lane_bus_t)-1:0] flat;
    for (int w = 0; w < $bits(flat) / 32; w++) begin
      flat[w*32 +: 32] = $random(seed);
    end
    return gty_rx_pkg::lane_bus_t'(flat);
  endfunction

  // output bit k takes input bit word_w-1-k
  function automatic gty_rx_pkg::lane_word_t reverse_word(input gty_rx_pkg::lane_word_t w);
    gty_rx_pkg::lane_word_t r;
    for (int k = 0; k < gty_rx_pkg::word_w; k++) begin
      r[k] = w[gty_rx_pkg::word_w-1-k];
    end
    return r;
  endfunction

  function automatic gty_rx_pkg::lane_bus_t expect_bus(
    input gty_rx_pkg::lane_bus_t          d,
    input logic [gty_rx_pkg::n_lanes-1:0] inj
  );
    gty_rx_pkg::lane_bus_t e;
    for (int i = 0; i < gty_rx_pkg::n_lanes; i++) begin
      e[i] = reverse_word(d[i]);
      if (inj[i]) begin
        e[i][130] = ~e[i][130];                 // err_bit 29 lands here after reversal
      end
    end
    return e;
  endfunction

  task automatic finish_test(input int t);
    repeat (3) @(posedge rx_usrclk);            // let the pipeline drain into the checks
    if (errs[t] == 0) begin
      $display("test %-12s : ok", test_name(t));
    end else begin
      $display("test %-12s : FAIL, %0d errors", test_name(t), errs[t]);
    end
  endtask

  ////////////////////
  // reference models

  gty_rx_pkg::lane_bus_t          exp_dout;     // expected dout, one cycle behind inputs
  logic [gty_rx_pkg::n_lanes-1:0] exp_locked;
  logic                           exp_valid;    // model holds a post reset word
  int                             exp_tag;      // test that drove the compared word

  always @(posedge rx_usrclk) begin
    if (rx_rst) begin
      exp_valid  <= 1'b0;
      exp_dout   <= '0;
      exp_locked <= '0;
      exp_tag    <= t_reset;
    end else begin
      exp_valid  <= 1'b1;
      exp_dout   <= expect_bus(rx_data, induce_error);
      exp_locked <= gt_status.powergood & gt_status.cdr_lock & gt_status.pma_reset_done;
      exp_tag    <= phase;
    end
  end

  logic [gty_rx_pkg::n_lanes-1:0] slip_s1, slip_s0;  // registered request and its history
  logic [gty_rx_pkg::n_lanes-1:0] slip_d1, slip_d2;  // edge delayed by one and two
  logic [gty_rx_pkg::n_lanes-1:0] exp_slide;

  always @(posedge rx_usrclk) begin
    slip_s1 <= gearbox_slip;
    slip_s0 <= slip_s1;
    if (rx_rst) begin
      slip_d1 <= '0;
      slip_d2 <= '0;
    end else begin
      slip_d1 <= slip_s1 & ~slip_s0;            // pulse starts the cycle after the edge
      slip_d2 <= slip_d1;
    end
  end

  assign exp_slide = slip_d1 | slip_d2;         // exactly two cycles per edge

  int gate_cyc;                                 // clk50 cycles in the current gate
  int gates_seen;                               // gate ends since reset
  int rate_seen;                                // rate_valid pulses since reset

  always @(posedge clk50) begin
    if (rst) begin
      gate_cyc   <= 0;
      gates_seen <= 0;
    end else if (gate_cyc == gate_len - 1) begin
      gate_cyc   <= 0;
      gates_seen <= gates_seen + 1;
    end else begin
      gate_cyc <= gate_cyc + 1;
    end
  end

  always @(posedge rx_usrclk) begin
    if (rx_rst) rate_seen <= 0;
    else if (rate_valid) rate_seen <= rate_seen + 1;
  end

  ////////////////////
  // checks

  a_reset : assert property (@(posedge rx_usrclk)
    $past(rx_rst) |-> {rxslide, locked, rate_valid} == '0
  ) else begin
    count_error(t_reset);
    $display("[FAIL] %s: expected %h, actual %h", test_name(t_reset), 25'h0,
             $sampled({rxslide, locked, rate_valid}));
  end

  a_data : assert property (@(posedge rx_usrclk) disable iff (rx_rst)
    exp_valid && exp_tag == t_data |-> dout == exp_dout
  ) else begin
    count_error(t_data);
    $display("[FAIL] %s: expected %h, actual %h", test_name(t_data),
             $sampled(exp_dout), $sampled(dout));
  end

  a_inject : assert property (@(posedge rx_usrclk) disable iff (rx_rst)
    exp_valid && exp_tag == t_inject |-> dout == exp_dout
  ) else begin
    count_error(t_inject);
    $display("[FAIL] %s: expected %h, actual %h", test_name(t_inject),
             $sampled(exp_dout), $sampled(dout));
  end

  a_slip : assert property (@(posedge rx_usrclk) disable iff (rx_rst)
    rxslide == exp_slide
  ) else begin
    count_error(t_slip);
    $display("[FAIL] %s: expected %h, actual %h", test_name(t_slip),
             $sampled(exp_slide), $sampled(rxslide));
  end

  a_lock : assert property (@(posedge rx_usrclk) disable iff (rx_rst)
    exp_valid |-> locked == exp_locked
  ) else begin
    count_error(t_lock);
    $display("[FAIL] %s: expected %h, actual %h", test_name(t_lock),
             $sampled(exp_locked), $sampled(locked));
  end

  a_rate : assert property (@(posedge rx_usrclk) disable iff (rx_rst)
    rate_valid |-> rate_count >= rate_nom - 1 && rate_count <= rate_nom + 1
  ) else begin
    count_error(t_meter);
    $display("[FAIL] %s: expected %0d +/- 1, actual %0d", test_name(t_meter),
             rate_nom, $sampled(rate_count));
  end

  a_rate_first : assert property (@(posedge rx_usrclk) disable iff (rx_rst)
    rate_valid |-> gates_seen >= 2
  ) else begin
    count_error(t_meter);
    $display("[FAIL] %s: expected gate ends >= 2, actual %0d", test_name(t_meter),
             $sampled(gates_seen));
  end

  ////////////////////
  // stimulus

  initial begin
    logic [31:0] rnd;
    logic [63:0] wide;
    int          nfail;
    rst          <= 1'b1;
    rx_rst       <= 1'b1;
    gearbox_slip <= '0;
    induce_error <= '0;
    rx_data      <= '0;
    gt_status    <= '1;                         // all lanes healthy outside the lock test
    phase        <= t_reset;
    repeat (8) @(posedge clk50);
    rst    <= 1'b0;
    @(posedge rx_usrclk);
    rx_rst <= 1'b0;                             // released on its own clock
    finish_test(t_reset);

    @(posedge rx_usrclk);
    phase <= t_data;
    repeat (200) begin
      @(posedge rx_usrclk);
      rx_data <= rand_bus();
    end
    finish_test(t_data);

    @(posedge rx_usrclk);
    phase <= t_inject;
    repeat (200) begin
      @(posedge rx_usrclk);
      rnd = $random(seed);
      rx_data      <= rand_bus();
      induce_error <= rnd[11:0];
    end
    @(posedge rx_usrclk);
    induce_error <= '0;
    finish_test(t_inject);

    @(posedge rx_usrclk);
    phase <= t_slip;
    repeat (20) begin
      @(posedge rx_usrclk);
      rnd = $random(seed);
      gearbox_slip <= rnd[11:0];
      repeat (3 + int'(rnd[18:16])) @(posedge rx_usrclk);  // held high, no second pulse
      gearbox_slip <= '0;
      repeat (4) @(posedge rx_usrclk);
    end
    finish_test(t_slip);

    @(posedge rx_usrclk);
    phase <= t_lock;
    repeat (200) begin
      @(posedge rx_usrclk);
      wide = {$random(seed), $random(seed)};
      gt_status <= gty_rx_pkg::gt_status_t'(wide[35:0]);
    end
    @(posedge rx_usrclk);
    gt_status <= '1;
    finish_test(t_lock);

    phase <= t_meter;
    wait (rate_seen >= 4);                      // meter runs from reset, collect a few reports
    finish_test(t_meter);

    nfail = 0;
    for (int t = 0; t < n_tests; t++) begin
      if (errs[t] != 0) nfail++;
    end
    $display("tests: %0d run, %0d ok, %0d failed", n_tests, n_tests - nfail, nfail);
    if (nfail == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  ////////////////////
  // watchdog

  initial begin
    #(wd_ns);
    $display("timeout: the run did not end within %0d ns", wd_ns);
    $display("Verification failed");
    $finish;
  end

endmodule

/* gty_rx_frontend.f */
src/gty_rx_pkg.sv
src/slip_pulse_gen.sv
src/lane_word_conditioner.sv
src/rx_clock_meter.sv
src/gty_rx_frontend.sv
test/tb_gty_rx_frontend.sv

/* Makefile */
# Verilator build and run for the gty rx front end

SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_gty_rx_frontend
FLIST    := gty_rx_frontend.f
OBJ_DIR  := obj_dir
EXE      := $(OBJ_DIR)/V$(TOP)
PASS_MSG := Verification passed

SOURCES  := $(shell cat $(FLIST))

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(FLIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# the run fails unless the pass message shows up in the output
run: compile
	@out="$$(./$(EXE))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
